// File: filelist.f
logic/z80_bus_pkg.sv
logic/z80_isa_pkg.sv
logic/ip_hello_world_rom.sv
logic/work_ram.sv
logic/uart_tx.sv
logic/system_bus.sv
logic/z80_lite_core.sv
logic/hello_system_top.sv
test/serial_monitor.sv
test/tb_hello_system.sv

// File: Bender.yml
package:
  name: hello_system

sources:
  - files:
      - logic/z80_bus_pkg.sv
      - logic/z80_isa_pkg.sv
      - logic/ip_hello_world_rom.sv
      - logic/work_ram.sv
      - logic/uart_tx.sv
      - logic/system_bus.sv
      - logic/z80_lite_core.sv
      - logic/hello_system_top.sv
  - target: test
    files:
      - test/serial_monitor.sv
      - test/tb_hello_system.sv

// File: test/tb_hello_system.sv
// hello world system testbench.
// Runs the boot program and checks the serial output and the halt flag.

`timescale 1ns/1ns

module tb_hello_system
	import z80_bus_pkg::*;
	import z80_isa_pkg::*;
();

	localparam int MSG_LEN        = 15;
	localparam int RESET_CYCLES   = 2;
	localparam int QUIET_CYCLES   = 200;
	localparam int FRAME_CYCLES   = 10 * UART_CLKS_PER_BIT;
	// three frame times per byte leave room for the busy polling and the calls.
	localparam int TIMEOUT_CYCLES = 3 * MSG_LEN * FRAME_CYCLES + QUIET_CYCLES + 200;

	logic       clk;
	logic       rst_n;
	logic       txd;
	logic       halted;
	logic       frame_start;
	logic       byte_valid;
	logic [7:0] byte_data;
	logic       frame_error;
	logic [7:0] expected_char;
	int         rx_count    = 0;
	int         starts_seen = 0;
	int         cycle_count = 0;

	hello_system_top UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.txd    (txd),
		.halted (halted)
	);

	serial_monitor u_monitor (
		.clk         (clk),
		.rst_n       (rst_n),
		.rxd         (txd),
		.frame_start (frame_start),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.frame_error (frame_error)
	);

	// the message is "Hello, world!" followed by CR and LF.
	function automatic logic [7:0] expected_byte(input int i);
		string text = "Hello, world!";
		if (i < text.len()) begin
			return text[i];
		end else if (i == text.len()) begin
			return 8'h0D;
		end else begin
			return 8'h0A;
		end
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first failed check");
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always_comb expected_char = (rx_count < MSG_LEN) ? expected_byte(rx_count) : 8'h00;

	always @(posedge clk) begin
		if (byte_valid) rx_count <= rx_count + 1;
		if (frame_start) starts_seen <= starts_seen + 1;
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout after %0d cycles with %0d bytes received",
				cycle_count, rx_count));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> (txd && !halted))
		else report_failure($sformatf("ERR txd = %h, halted = %h right after reset",
			$sampled(txd), $sampled(halted)));

	a_txd_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(txd))
		else report_failure("the serial line went to an unknown level");

	a_frame_ok: assert property (@(posedge clk) disable iff (!rst_n) !frame_error)
		else report_failure("a frame had a bad start or stop bit");

	a_byte_value: assert property (@(posedge clk) disable iff (!rst_n)
		byte_valid |-> (byte_data == expected_char))
		else report_failure($sformatf("ERR byte_data = %02h, expected %02h at index %0d",
			$sampled(byte_data), $sampled(expected_char), $sampled(rx_count)));

	a_byte_count: assert property (@(posedge clk) disable iff (!rst_n)
		byte_valid |-> (rx_count < MSG_LEN))
		else report_failure("a byte arrived after the whole message");

	a_frame_count: assert property (@(posedge clk) disable iff (!rst_n)
		frame_start |-> (starts_seen < MSG_LEN))
		else report_failure("a frame started after the whole message was sent");

	// the last byte may still be on the line when the core halts.
	a_halt_timing: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> (starts_seen == MSG_LEN))
		else report_failure("the core halted before the whole message was sent");

	a_halt_op: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(halted) |-> (UUT.u_core.op == HALT))
		else report_failure($sformatf("ERR UUT.u_core.op = %02h, expected %02h",
			$sampled(UUT.u_core.op), HALT));

	a_halt_holds: assert property (@(posedge clk) disable iff (!rst_n) !$fell(halted))
		else report_failure("halted dropped without a reset");

	a_idle_after_message: assert property (@(posedge clk) disable iff (!rst_n)
		(rx_count == MSG_LEN) |-> txd)
		else report_failure($sformatf("ERR txd = %h after the last byte", $sampled(txd)));

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// the program runs by itself; wait for the whole message and the halt.
		while (!(rx_count == MSG_LEN && halted)) begin
			@(posedge clk);
		end
		repeat (QUIET_CYCLES) @(posedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: test/serial_monitor.sv
// serial line monitor.
// Rebuilds 8N1 bytes from the transmit line and flags bad frames.

`timescale 1ns/1ns

module serial_monitor
	import z80_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rxd,
	output logic       frame_start,
	output logic       byte_valid,
	output logic [7:0] byte_data,
	output logic       frame_error
);

	localparam int HALF_BIT = UART_CLKS_PER_BIT / 2;

	logic       rxd_q;
	logic       active;
	logic [3:0] bit_idx;
	int         wait_cnt;
	logic [7:0] shift;

	always_ff @(posedge clk) begin
		frame_start <= 1'b0;
		byte_valid  <= 1'b0;
		frame_error <= 1'b0;
		if (!rst_n) begin
			rxd_q     <= 1'b1;
			active    <= 1'b0;
			bit_idx   <= '0;
			wait_cnt  <= 0;
			shift     <= '0;
			byte_data <= '0;
		end else begin
			rxd_q <= rxd;
			if (!active) begin
				// a falling edge on the idle line opens a frame.
				if (rxd_q && !rxd) begin
					active      <= 1'b1;
					frame_start <= 1'b1;
					bit_idx     <= '0;
					wait_cnt    <= HALF_BIT;
				end
			end else if (wait_cnt > 1) begin
				wait_cnt <= wait_cnt - 1;
			end else begin
				// this is the middle of a bit period.
				wait_cnt <= UART_CLKS_PER_BIT;
				bit_idx  <= bit_idx + 4'd1;
				if (bit_idx == 4'd0) begin
					// a start bit that is already high again is a glitch.
					if (rxd) begin
						frame_error <= 1'b1;
						active      <= 1'b0;
					end
				end else if (bit_idx < 4'd9) begin
					shift <= {rxd, shift[7:1]};
				end else begin
					active <= 1'b0;
					if (rxd) begin
						byte_valid <= 1'b1;
						byte_data  <= shift;
					end else begin
						frame_error <= 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: logic/hello_system_top.sv
// hello world system.
// Core, bus, program rom, stack ram and serial transmitter.

`timescale 1ns/1ns

module hello_system_top
	import z80_bus_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	output logic txd,
	output logic halted
);

	bus_req_t                 bus_req;
	logic [7:0]               rdata;
	logic                     rdata_en;
	logic                     rom_n_cs;
	logic                     rom_n_rd;
	logic [ROM_ADDR_BITS-1:0] rom_address;
	logic [7:0]               rom_rdata;
	logic                     rom_rdata_en;
	logic                     ram_cs;
	logic                     ram_we;
	logic [RAM_ADDR_BITS-1:0] ram_addr;
	logic [7:0]               ram_wdata;
	logic [7:0]               ram_rdata;
	logic                     ram_rdata_en;
	logic                     uart_send;
	logic [7:0]               uart_data;
	logic                     uart_busy;

	z80_lite_core u_core (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus_req  (bus_req),
		.rdata    (rdata),
		.rdata_en (rdata_en),
		.halted   (halted)
	);

	system_bus u_bus (
		.clk          (clk),
		.rst_n        (rst_n),
		.bus_req      (bus_req),
		.rdata        (rdata),
		.rdata_en     (rdata_en),
		.rom_n_cs     (rom_n_cs),
		.rom_n_rd     (rom_n_rd),
		.rom_address  (rom_address),
		.rom_rdata    (rom_rdata),
		.rom_rdata_en (rom_rdata_en),
		.ram_cs       (ram_cs),
		.ram_we       (ram_we),
		.ram_addr     (ram_addr),
		.ram_wdata    (ram_wdata),
		.ram_rdata    (ram_rdata),
		.ram_rdata_en (ram_rdata_en),
		.uart_send    (uart_send),
		.uart_data    (uart_data),
		.uart_busy    (uart_busy)
	);

	ip_hello_world_rom u_rom (
		.clk      (clk),
		.rst_n    (rst_n),
		.n_cs     (rom_n_cs),
		.n_rd     (rom_n_rd),
		.address  (rom_address),
		.rdata    (rom_rdata),
		.rdata_en (rom_rdata_en)
	);

	work_ram u_ram (
		.clk      (clk),
		.rst_n    (rst_n),
		.cs       (ram_cs),
		.we       (ram_we),
		.addr     (ram_addr),
		.wdata    (ram_wdata),
		.rdata    (ram_rdata),
		.rdata_en (ram_rdata_en)
	);

	uart_tx u_uart (
		.clk   (clk),
		.rst_n (rst_n),
		.send  (uart_send),
		.data  (uart_data),
		.txd   (txd),
		.busy  (uart_busy)
	);

endmodule

// File: logic/z80_lite_core.sv
// reduced z80 core.
// Multicycle fetch and execute for the opcode subset the boot rom uses.

`timescale 1ns/1ns

module z80_lite_core
	import z80_bus_pkg::*;
	import z80_isa_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	output bus_req_t   bus_req,
	input  logic [7:0] rdata,
	input  logic       rdata_en,
	output logic       halted
);

	core_state_e state;
	opcode_e     op;
	logic [15:0] pc;
	logic [15:0] sp;
	logic [15:0] hl;
	logic [7:0]  a;
	logic [7:0]  b;
	logic [7:0]  c;
	logic [7:0]  flags;
	// operand bytes arrive low first and shift down, so a single byte ends up in [15:8].
	logic [15:0] imm;
	logic [1:0]  opnd_left;
	logic [15:0] jr_target;
	logic [7:0]  rr_b;
	logic        rd_cycle;
	logic        out_cycle;

	function automatic logic [1:0] operand_bytes(input opcode_e o);
		case (o)
			LD_SP_NN, LD_HL_NN, CALL_NN: return 2'd2;
			LD_C_N, JR_C, JR, PREFIX_CB, PREFIX_ED: return 2'd1;
			default: return 2'd0;
		endcase
	endfunction

	assign jr_target = pc + {{8{imm[15]}}, imm[15:8]};
	assign rr_b      = {flags[FLAG_C], b[7:1]};

	////////////////////////////////////////////////////////////////////////////
	// bus request
	////////////////////////////////////////////////////////////////////////////

	assign rd_cycle  = state inside {FETCH, OPERAND, POP_LO, POP_HI, MEM_RD, IO_RD};
	assign out_cycle = (state == EXEC) && (op == PREFIX_ED) && (imm[15:8] == ED_OUT_C_A);

	always_comb begin
		bus_req = '0;
		case (state)
			FETCH, OPERAND: bus_req.addr = pc;
			PUSH_HI, PUSH_LO: bus_req.addr = sp - 16'd1;
			POP_LO, POP_HI: bus_req.addr = sp;
			MEM_RD: bus_req.addr = hl;
			default: bus_req.addr = {b, c};
		endcase
		// rd drops in the cycle the reply arrives, so each read costs two cycles.
		bus_req.rd = rd_cycle && !rdata_en;
		bus_req.wr = (state == PUSH_HI) || (state == PUSH_LO) || out_cycle;
		bus_req.io = (state == IO_RD) || out_cycle;
		if (state == PUSH_HI) begin
			bus_req.wdata = pc[15:8];
		end else if (state == PUSH_LO) begin
			bus_req.wdata = pc[7:0];
		end else begin
			bus_req.wdata = a;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= FETCH;
			pc        <= 16'h0000;
			opnd_left <= 2'd0;
		end else begin
			case (state)
				FETCH: if (rdata_en) begin
					op        <= opcode_e'(rdata);
					pc        <= pc + 16'd1;
					opnd_left <= operand_bytes(opcode_e'(rdata));
					if (operand_bytes(opcode_e'(rdata)) == 2'd0) begin
						state <= EXEC;
					end else begin
						state <= OPERAND;
					end
				end
				OPERAND: if (rdata_en) begin
					imm       <= {rdata, imm[15:8]};
					pc        <= pc + 16'd1;
					opnd_left <= opnd_left - 2'd1;
					if (opnd_left == 2'd1) begin
						state <= EXEC;
					end
				end
				EXEC: begin
					state <= FETCH;
					case (op)
						// there are no interrupts, so DI has nothing to disable.
						DI: ;
						LD_SP_NN: sp <= imm;
						LD_HL_NN: hl <= imm;
						CALL_NN: state <= PUSH_HI;
						HALT: state <= HALTED;
						LD_C_N: c <= imm[15:8];
						JR_C: if (flags[FLAG_C]) pc <= jr_target;
						JR: pc <= jr_target;
						RET: state <= POP_LO;
						RET_Z: if (flags[FLAG_Z]) state <= POP_LO;
						LD_A_HL: state <= MEM_RD;
						INC_HL: hl <= hl + 16'd1;
						OR_A: begin
							flags[FLAG_Z] <= (a == 8'h00);
							flags[FLAG_C] <= 1'b0;
						end
						PREFIX_CB: if (imm[15:8] == CB_RR_B) begin
							b             <= rr_b;
							flags[FLAG_C] <= b[0];
							flags[FLAG_Z] <= (rr_b == 8'h00);
						end else begin
							state <= HALTED;
						end
						// OUT (C),A needs no state of its own. The write strobe is this cycle.
						PREFIX_ED: if (imm[15:8] == ED_IN_B_C) begin
							state <= IO_RD;
						end else if (imm[15:8] != ED_OUT_C_A) begin
							state <= HALTED;
						end
						default: state <= HALTED;
					endcase
				end
				// return address goes high byte first, at SP-1 then SP-2.
				PUSH_HI: begin
					sp    <= sp - 16'd1;
					state <= PUSH_LO;
				end
				PUSH_LO: begin
					sp    <= sp - 16'd1;
					pc    <= imm;
					state <= FETCH;
				end
				POP_LO: if (rdata_en) begin
					pc[7:0] <= rdata;
					sp      <= sp + 16'd1;
					state   <= POP_HI;
				end
				POP_HI: if (rdata_en) begin
					pc[15:8] <= rdata;
					sp       <= sp + 16'd1;
					state    <= FETCH;
				end
				MEM_RD: if (rdata_en) begin
					a     <= rdata;
					state <= FETCH;
				end
				IO_RD: if (rdata_en) begin
					b             <= rdata;
					flags[FLAG_Z] <= (rdata == 8'h00);
					state         <= FETCH;
				end
				HALTED: state <= HALTED;
				default: state <= HALTED;
			endcase
		end
	end

	assign halted = (state == HALTED);

	a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(bus_req.rd && bus_req.wr));

endmodule

// File: logic/system_bus.sv
// system bus.
// Decodes core cycles onto rom, ram and the serial port and merges read data.

`timescale 1ns/1ns

module system_bus
	import z80_bus_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  bus_req_t                 bus_req,
	output logic [7:0]               rdata,
	output logic                     rdata_en,
	output logic                     rom_n_cs,
	output logic                     rom_n_rd,
	output logic [ROM_ADDR_BITS-1:0] rom_address,
	input  logic [7:0]               rom_rdata,
	input  logic                     rom_rdata_en,
	output logic                     ram_cs,
	output logic                     ram_we,
	output logic [RAM_ADDR_BITS-1:0] ram_addr,
	output logic [7:0]               ram_wdata,
	input  logic [7:0]               ram_rdata,
	input  logic                     ram_rdata_en,
	output logic                     uart_send,
	output logic [7:0]               uart_data,
	input  logic                     uart_busy
);

	logic       rom_sel;
	logic       ram_sel;
	logic       uart_sel;
	logic       access;
	logic [7:0] port_rdata;
	logic       port_rdata_en;
	logic       unmapped_en;

	assign access   = bus_req.rd || bus_req.wr;
	assign rom_sel  = !bus_req.io && (bus_req.addr[15:ROM_ADDR_BITS] == '0);
	assign ram_sel  = !bus_req.io &&
		(bus_req.addr[15:RAM_ADDR_BITS] == RAM_BASE[15:RAM_ADDR_BITS]);
	// only the low byte of an I/O address names the port.
	assign uart_sel = bus_req.io && (bus_req.addr[7:0] == UART_PORT);

	assign rom_n_cs    = !(rom_sel && access);
	assign rom_n_rd    = !bus_req.rd;
	assign rom_address = bus_req.addr[ROM_ADDR_BITS-1:0];

	assign ram_cs    = ram_sel && access;
	assign ram_we    = ram_sel && bus_req.wr;
	assign ram_addr  = bus_req.addr[RAM_ADDR_BITS-1:0];
	assign ram_wdata = bus_req.wdata;

	assign uart_send = uart_sel && bus_req.wr;
	assign uart_data = bus_req.wdata;

	// the port read and the unmapped reply take one cycle, just like the memories.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			port_rdata    <= 8'h00;
			port_rdata_en <= 1'b0;
			unmapped_en   <= 1'b0;
		end else begin
			port_rdata    <= (uart_sel && bus_req.rd) ? {7'b0, uart_busy} : 8'h00;
			port_rdata_en <= uart_sel && bus_req.rd;
			unmapped_en   <= bus_req.rd && !rom_sel && !ram_sel && !uart_sel;
		end
	end

	// idle targets drive zero, so a plain OR merges the replies.
	assign rdata    = rom_rdata | ram_rdata | port_rdata;
	assign rdata_en = rom_rdata_en | ram_rdata_en | port_rdata_en | unmapped_en;

	a_one_reply: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({rom_rdata_en, ram_rdata_en, port_rdata_en, unmapped_en}));

endmodule

// File: logic/uart_tx.sv
// serial transmitter.
// Sends one 8N1 frame per send strobe and reports busy while shifting.

`timescale 1ns/1ns

module uart_tx
	import z80_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       send,
	input  logic [7:0] data,
	output logic       txd,
	output logic       busy
);

	// frame bits go out from bit 0 with the start bit first and the stop bit last.
	logic [9:0]               frame;
	logic [UART_CNT_BITS-1:0] clk_cnt;
	logic [3:0]               bit_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame   <= '1;
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (send) begin
				frame   <= {1'b1, data, 1'b0};
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == UART_CNT_BITS'(UART_CLKS_PER_BIT - 1)) begin
			// end of a bit period. Shift in idle level behind the frame.
			clk_cnt <= '0;
			frame   <= {1'b1, frame[9:1]};
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign txd = frame[0];

	// the program polls busy before each byte, so no send may land mid-frame.
	a_no_send_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		send |-> !busy);

endmodule

// File: logic/work_ram.sv
// work ram.
// 256-byte stack memory with the rom's registered read timing.

`timescale 1ns/1ns

module work_ram
	import z80_bus_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cs,
	input  logic                     we,
	input  logic [RAM_ADDR_BITS-1:0] addr,
	input  logic [7:0]               wdata,
	output logic [7:0]               rdata,
	output logic                     rdata_en
);

	logic [7:0] mem [2**RAM_ADDR_BITS];

	always_ff @(posedge clk) begin
		if (cs && we) begin
			mem[addr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata    <= 8'h00;
			rdata_en <= 1'b0;
		end else if (cs && !we) begin
			rdata    <= mem[addr];
			rdata_en <= 1'b1;
		end else begin
			rdata    <= 8'h00;
			rdata_en <= 1'b0;
		end
	end

	// the core must present a settled stack address whenever it selects the ram.
	a_ram_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		(cs || we) |-> !$isunknown(addr));

endmodule

// File: logic/ip_hello_world_rom.sv
// hello world program rom.
// Fixed boot program and its string, read through a registered port.

`timescale 1ns/1ns

module ip_hello_world_rom
	import z80_bus_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     n_cs,
	input  logic                     n_rd,
	input  logic [ROM_ADDR_BITS-1:0] address,
	output logic [7:0]               rdata,
	output logic                     rdata_en
);

	function automatic logic [7:0] rom_byte(input logic [ROM_ADDR_BITS-1:0] a);
		case (a)
			// the boot code runs DI, LD SP,7FFEh, LD HL,msg, CALL puts and HALT.
			'h00: return 8'hF3;
			'h01: return 8'h31;
			'h02: return 8'hFE;
			'h03: return 8'h7F;
			'h04: return 8'h21;
			'h05: return 8'h1F;
			'h06: return 8'h00;
			'h07: return 8'hCD;
			'h08: return 8'h16;
			'h09: return 8'h00;
			'h0A: return 8'h76;
			// putc polls busy on port 10h until it clears and then sends A.
			'h0B: return 8'h0E;
			'h0C: return 8'h10;
			'h0D: return 8'hED;
			'h0E: return 8'h40;
			'h0F: return 8'hCB;
			'h10: return 8'h18;
			'h11: return 8'h38;
			'h12: return 8'hFA;
			'h13: return 8'hED;
			'h14: return 8'h79;
			'h15: return 8'hC9;
			// puts walks the string at HL until the zero terminator.
			'h16: return 8'h7E;
			'h17: return 8'h23;
			'h18: return 8'hB7;
			'h19: return 8'hC8;
			'h1A: return 8'hCD;
			'h1B: return 8'h0B;
			'h1C: return 8'h00;
			'h1D: return 8'h18;
			'h1E: return 8'hF7;
			// "Hello, world!" CR LF and terminator.
			'h1F: return 8'h48;
			'h20: return 8'h65;
			'h21: return 8'h6C;
			'h22: return 8'h6C;
			'h23: return 8'h6F;
			'h24: return 8'h2C;
			'h25: return 8'h20;
			'h26: return 8'h77;
			'h27: return 8'h6F;
			'h28: return 8'h72;
			'h29: return 8'h6C;
			'h2A: return 8'h64;
			'h2B: return 8'h21;
			'h2C: return 8'h0D;
			'h2D: return 8'h0A;
			'h2E: return 8'h00;
			default: return 8'h00;
		endcase
	endfunction

	// data and valid are cleared whenever the rom is not being read.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata    <= 8'h00;
			rdata_en <= 1'b0;
		end else if (!n_cs && !n_rd) begin
			rdata    <= rom_byte(address);
			rdata_en <= 1'b1;
		end else begin
			rdata    <= 8'h00;
			rdata_en <= 1'b0;
		end
	end

endmodule

// File: logic/z80_isa_pkg.sv
// z80 subset definitions.
// First-byte opcodes, prefixed second bytes, sequencer states and flag bits.

package z80_isa_pkg;

	// first opcode bytes of the supported instructions.
	typedef enum logic [7:0] {
		DI        = 8'hF3,
		LD_SP_NN  = 8'h31,
		LD_HL_NN  = 8'h21,
		CALL_NN   = 8'hCD,
		HALT      = 8'h76,
		LD_C_N    = 8'h0E,
		JR_C      = 8'h38,
		JR        = 8'h18,
		RET       = 8'hC9,
		RET_Z     = 8'hC8,
		LD_A_HL   = 8'h7E,
		INC_HL    = 8'h23,
		OR_A      = 8'hB7,
		PREFIX_CB = 8'hCB,
		PREFIX_ED = 8'hED
	} opcode_e;

	// second bytes after a prefix.
	localparam logic [7:0] CB_RR_B    = 8'h18;
	localparam logic [7:0] ED_IN_B_C  = 8'h40;
	localparam logic [7:0] ED_OUT_C_A = 8'h79;

	// sequencer states of the core.
	typedef enum logic [3:0] {
		FETCH,
		OPERAND,
		EXEC,
		PUSH_HI,
		PUSH_LO,
		POP_LO,
		POP_HI,
		MEM_RD,
		IO_RD,
		HALTED
	} core_state_e;

	// the flag bits sit where the real part keeps them.
	localparam int FLAG_Z = 6;
	localparam int FLAG_C = 0;

endpackage

// File: logic/z80_bus_pkg.sv
// z80 bus definitions.
// Memory map, I/O port numbers, serial timing and the core's bus request.

package z80_bus_pkg;

	// rom occupies 0000h to 3FFFh, selected when the upper address bits are zero.
	localparam int ROM_ADDR_BITS = 14;

	// the work ram is a single 256-byte page at the top of the lower half.
	localparam logic [15:0] RAM_BASE = 16'h7F00;
	localparam int RAM_ADDR_BITS = 8;

	// the serial port is the only I/O port. Bit 0 of a read is busy.
	localparam logic [7:0] UART_PORT = 8'h10;

	// serial bit period in clock cycles, and the counter width it needs.
	localparam int UART_CLKS_PER_BIT = 8;
	localparam int UART_CNT_BITS = $clog2(UART_CLKS_PER_BIT);

	// one core bus cycle. rd is held until rdata_en; wr lasts one cycle.
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
		logic        io;
	} bus_req_t;

endpackage
